/* dpath_params.svh */
// Datapath parameters
// Architectural widths, register count, PC step and reset vector

`ifndef DPATH_PARAMS_SVH
`define DPATH_PARAMS_SVH

`define DPATH_XLEN         32            // Data and address width
`define DPATH_NUM_REGS     32            // Integer register count
`define DPATH_PC_STEP      32'd4         // Sequential PC increment
`define DPATH_RESET_VECTOR 32'h00080000  // First fetch address

`endif

/* riscv_isa_pkg.sv */
// RISC-V ISA types
// Machine words, register indices and raw instruction words

`include "dpath_params.svh"

package riscv_isa_pkg;

  // ------------------------------
  // Base types
  // ------------------------------

  typedef logic [`DPATH_XLEN-1:0] word_t;   // Data or address word
  typedef logic [4:0]             reg_addr_t; // rs1, rs2 or rd index
  typedef logic [31:0]            inst_t;   // Raw instruction word

endpackage

/* dpath_ctrl_pkg.sv */
// Datapath control encodings
// Select codes the external controller drives into each stage

package dpath_ctrl_pkg;

  // Operand 0 mux in D
  typedef enum logic [1:0] {
    op0_rs1  = 2'd0,  // rs1 register value
    op0_pc   = 2'd1,  // Current D-stage PC
    op0_pc4  = 2'd2,  // PC + 4
    op0_zero = 2'd3
  } op0_sel_e;

  // Operand 1 mux in D
  typedef enum logic [2:0] {
    op1_rs2    = 3'd0,  // rs2 register value
    op1_shamt  = 3'd1,  // Zero-extended shift amount
    op1_imm_u  = 3'd2,
    op1_imm_sb = 3'd3,
    op1_imm_i  = 3'd4,
    op1_imm_s  = 3'd5,
    op1_zero   = 3'd6
  } op1_sel_e;

  // ALU function in X
  typedef enum logic [3:0] {
    alu_add = 4'd0,
    alu_sub = 4'd1,
    alu_sll = 4'd2,
    alu_or  = 4'd3,
    alu_lt  = 4'd4,
    alu_ltu = 4'd5,
    alu_and = 4'd6,
    alu_xor = 4'd7,
    alu_nor = 4'd8,
    alu_srl = 4'd9,
    alu_sra = 4'd10
  } alu_fn_e;

  // Redirect target select in X
  typedef enum logic [1:0] {
    brj_pc4    = 2'd0,
    brj_branch = 2'd1,  // pc + imm_sb
    brj_jump   = 2'd2,  // pc + imm_uj
    brj_jreg   = 2'd3   // rs1 + imm_i
  } brj_sel_e;

  // Load extraction in M
  typedef enum logic [2:0] {
    resp_w  = 3'd0,  // Full word
    resp_b  = 3'd1,  // Byte, sign-extended
    resp_bu = 3'd2,  // Byte, zero-extended
    resp_h  = 3'd3,  // Half, sign-extended
    resp_hu = 3'd4   // Half, zero-extended
  } mem_resp_sel_e;

  // Writeback source in M
  typedef enum logic {
    wb_exec = 1'b0,
    wb_mem  = 1'b1
  } wb_sel_e;

endpackage

/* fetch_unit.sv */
// Fetch unit
// PC register with sequential advance or redirect from execute

`include "dpath_params.svh"

module fetch_unit (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 stall_f,
  input  logic                 brj_taken_x,        // Redirect decided in X
  input  riscv_isa_pkg::word_t redirect_target_x,
  output riscv_isa_pkg::word_t pc_f,
  output riscv_isa_pkg::word_t imem_addr
);

  riscv_isa_pkg::word_t pc_next;

  // ------------------------------
  // Next PC
  // ------------------------------

  // Redirect wins over sequential advance
  assign pc_next = brj_taken_x ? redirect_target_x : pc_f + `DPATH_PC_STEP;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc_f <= `DPATH_RESET_VECTOR;
    end else if (!stall_f) begin
      pc_f <= pc_next;
    end
    // Stalled PC holds
  end

  assign imem_addr = pc_f;  // Request goes out straight from the register

endmodule

/* regfile.sv */
// Register file
// Two combinational read ports, one write port, x0 hardwired to zero

`include "dpath_params.svh"

module regfile (
  input  logic                     clk,
  input  riscv_isa_pkg::reg_addr_t raddr0,
  input  riscv_isa_pkg::reg_addr_t raddr1,
  output riscv_isa_pkg::word_t     rdata0,
  output riscv_isa_pkg::word_t     rdata1,
  input  logic                     wen,
  input  riscv_isa_pkg::reg_addr_t waddr,
  input  riscv_isa_pkg::word_t     wdata
);

  riscv_isa_pkg::word_t regs [`DPATH_NUM_REGS];

  always_ff @(posedge clk) begin
    if (wen && (waddr != '0)) begin  // Writes to x0 dropped
      regs[waddr] <= wdata;
    end
  end

  // No bypass, same-cycle write shows next cycle
  assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

endmodule

/* decode_stage.sv */
// Decode stage
// F-to-D PC register, immediate extraction, register read and operand muxes

`include "dpath_params.svh"

module decode_stage (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          stall_d,
  input  riscv_isa_pkg::word_t          pc_f,
  input  riscv_isa_pkg::inst_t          inst_d,
  input  dpath_ctrl_pkg::op0_sel_e      op0_sel_d,
  input  dpath_ctrl_pkg::op1_sel_e      op1_sel_d,
  input  logic                          rf_wen_w,
  input  riscv_isa_pkg::reg_addr_t      rf_waddr_w,
  input  riscv_isa_pkg::word_t          wb_data_w,
  output riscv_isa_pkg::word_t          pc_d,
  output riscv_isa_pkg::word_t          op0_d,
  output riscv_isa_pkg::word_t          op1_d,
  output riscv_isa_pkg::word_t          rs1_val_d,
  output riscv_isa_pkg::word_t          rs2_val_d,
  output riscv_isa_pkg::word_t          imm_i_d,
  output riscv_isa_pkg::word_t          imm_sb_d,
  output riscv_isa_pkg::word_t          imm_uj_d
);

  riscv_isa_pkg::reg_addr_t rs1_d;
  riscv_isa_pkg::reg_addr_t rs2_d;
  riscv_isa_pkg::word_t     shamt_d;
  riscv_isa_pkg::word_t     imm_s_d;
  riscv_isa_pkg::word_t     imm_u_d;

  // ------------------------------
  // D <- F
  // ------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      pc_d <= '0;
    end else if (!stall_d) begin
      pc_d <= pc_f;
    end
  end

  // ------------------------------
  // Instruction fields
  // ------------------------------

  assign rs1_d   = inst_d[19:15];
  assign rs2_d   = inst_d[24:20];
  assign shamt_d = {27'b0, inst_d[24:20]};  // Same bits as rs2

  assign imm_i_d  = {{20{inst_d[31]}}, inst_d[31:20]};
  assign imm_s_d  = {{20{inst_d[31]}}, inst_d[31:25], inst_d[11:7]};
  assign imm_sb_d = {{19{inst_d[31]}}, inst_d[31], inst_d[7],
                     inst_d[30:25], inst_d[11:8], 1'b0};      // Halfword aligned
  assign imm_u_d  = {inst_d[31:12], 12'b0};
  assign imm_uj_d = {{11{inst_d[31]}}, inst_d[31], inst_d[19:12],
                     inst_d[20], inst_d[30:21], 1'b0};

  // Register read, write port driven from W
  regfile u_regfile (
    .clk    (clk),
    .raddr0 (rs1_d),
    .raddr1 (rs2_d),
    .rdata0 (rs1_val_d),
    .rdata1 (rs2_val_d),
    .wen    (rf_wen_w),
    .waddr  (rf_waddr_w),
    .wdata  (wb_data_w)
  );

  // ------------------------------
  // Operand muxes
  // ------------------------------

  always_comb begin
    case (op0_sel_d)
      dpath_ctrl_pkg::op0_rs1: op0_d = rs1_val_d;
      dpath_ctrl_pkg::op0_pc:  op0_d = pc_d;
      dpath_ctrl_pkg::op0_pc4: op0_d = pc_d + `DPATH_PC_STEP;  // Link value
      default:                 op0_d = '0;
    endcase
  end

  always_comb begin
    case (op1_sel_d)
      dpath_ctrl_pkg::op1_rs2:    op1_d = rs2_val_d;
      dpath_ctrl_pkg::op1_shamt:  op1_d = shamt_d;
      dpath_ctrl_pkg::op1_imm_u:  op1_d = imm_u_d;   // lui, auipc
      dpath_ctrl_pkg::op1_imm_sb: op1_d = imm_sb_d;
      dpath_ctrl_pkg::op1_imm_i:  op1_d = imm_i_d;
      dpath_ctrl_pkg::op1_imm_s:  op1_d = imm_s_d;   // Store address offset
      default:                    op1_d = '0;
    endcase
  end

endmodule

/* alu.sv */
// ALU
// Eleven integer functions, purely combinational

module alu (
  input  riscv_isa_pkg::word_t    in0,
  input  riscv_isa_pkg::word_t    in1,
  input  dpath_ctrl_pkg::alu_fn_e fn,
  output riscv_isa_pkg::word_t    out
);

  logic [4:0] shamt;

  assign shamt = in1[4:0];  // RV32 shifts use low five bits

  always_comb begin
    case (fn)
      dpath_ctrl_pkg::alu_add: out = in0 + in1;
      dpath_ctrl_pkg::alu_sub: out = in0 - in1;
      dpath_ctrl_pkg::alu_sll: out = in0 << shamt;
      dpath_ctrl_pkg::alu_or:  out = in0 | in1;
      // Set-less-than results zero-extended to a word
      dpath_ctrl_pkg::alu_lt:  out = {31'b0, $signed(in0) < $signed(in1)};
      dpath_ctrl_pkg::alu_ltu: out = {31'b0, in0 < in1};
      dpath_ctrl_pkg::alu_and: out = in0 & in1;
      dpath_ctrl_pkg::alu_xor: out = in0 ^ in1;
      dpath_ctrl_pkg::alu_nor: out = ~(in0 | in1);
      dpath_ctrl_pkg::alu_srl: out = in0 >> shamt;
      dpath_ctrl_pkg::alu_sra: out = $signed(in0) >>> shamt;  // Keeps sign bit
      default:                 out = '0;
    endcase
  end

endmodule

/* execute_stage.sv */
// Execute stage
// D-to-X registers, ALU, branch flags, redirect target and memory request

`include "dpath_params.svh"

module execute_stage (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     stall_x,
  input  riscv_isa_pkg::word_t     pc_d,
  input  riscv_isa_pkg::word_t     op0_d,
  input  riscv_isa_pkg::word_t     op1_d,
  input  riscv_isa_pkg::word_t     rs1_val_d,
  input  riscv_isa_pkg::word_t     rs2_val_d,
  input  riscv_isa_pkg::word_t     imm_i_d,
  input  riscv_isa_pkg::word_t     imm_sb_d,
  input  riscv_isa_pkg::word_t     imm_uj_d,
  input  dpath_ctrl_pkg::alu_fn_e  alu_fn_x,
  input  dpath_ctrl_pkg::brj_sel_e brj_sel_x,
  input  logic                     brj_taken_x,
  output riscv_isa_pkg::word_t     exec_result_x,
  output riscv_isa_pkg::word_t     store_data_x,
  output riscv_isa_pkg::word_t     redirect_target_x,
  output riscv_isa_pkg::word_t     dmem_req_addr,
  output riscv_isa_pkg::word_t     dmem_req_data,
  output logic                     branch_cond_eq_x,
  output logic                     branch_cond_ne_x,
  output logic                     branch_cond_lt_x,
  output logic                     branch_cond_ltu_x,
  output logic                     branch_cond_ge_x,
  output logic                     branch_cond_geu_x
);

  riscv_isa_pkg::word_t     pc_x;
  riscv_isa_pkg::word_t     op0_x;
  riscv_isa_pkg::word_t     op1_x;
  riscv_isa_pkg::word_t     rs1_val_x;
  riscv_isa_pkg::word_t     rs2_val_x;
  riscv_isa_pkg::word_t     imm_i_x;
  riscv_isa_pkg::word_t     imm_sb_x;
  riscv_isa_pkg::word_t     imm_uj_x;
  riscv_isa_pkg::word_t     alu_out_x;

  // ------------------------------
  // X <- D
  // ------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      pc_x      <= '0;
      op0_x     <= '0;
      op1_x     <= '0;
      rs1_val_x <= '0;
      rs2_val_x <= '0;
      imm_i_x   <= '0;
      imm_sb_x  <= '0;
      imm_uj_x  <= '0;
    end else if (!stall_x) begin
      pc_x      <= pc_d;
      op0_x     <= op0_d;
      op1_x     <= op1_d;
      rs1_val_x <= rs1_val_d;
      rs2_val_x <= rs2_val_d;  // Store data rides along
      imm_i_x   <= imm_i_d;
      imm_sb_x  <= imm_sb_d;
      imm_uj_x  <= imm_uj_d;
    end
  end

  alu u_alu (
    .in0 (op0_x),
    .in1 (op1_x),
    .fn  (alu_fn_x),
    .out (alu_out_x)
  );

  // Flags compare the two operands directly, not the ALU result
  assign branch_cond_eq_x  = (op0_x == op1_x);
  assign branch_cond_ne_x  = (op0_x != op1_x);
  assign branch_cond_lt_x  = ($signed(op0_x) <  $signed(op1_x));
  assign branch_cond_ltu_x = (op0_x <  op1_x);
  assign branch_cond_ge_x  = ($signed(op0_x) >= $signed(op1_x));
  assign branch_cond_geu_x = (op0_x >= op1_x);

  // ------------------------------
  // Redirect target
  // ------------------------------

  // Fetch only takes the target when brj_taken_x is high
  always_comb begin
    case (brj_sel_x)
      dpath_ctrl_pkg::brj_branch: redirect_target_x = pc_x + imm_sb_x;
      dpath_ctrl_pkg::brj_jump:   redirect_target_x = pc_x + imm_uj_x;  // jal
      dpath_ctrl_pkg::brj_jreg:   redirect_target_x = rs1_val_x + imm_i_x; // jalr
      default:                    redirect_target_x = pc_x + `DPATH_PC_STEP;
    endcase
  end

  // Memory request leaves in X, response returns in M
  assign exec_result_x = alu_out_x;
  assign store_data_x  = rs2_val_x;
  assign dmem_req_addr = alu_out_x;  // Effective address from add
  assign dmem_req_data = rs2_val_x;

endmodule

/* mem_wb_stage.sv */
// Memory and writeback stages
// X-to-M register, load extraction, writeback mux and M-to-W register

module mem_wb_stage (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          stall_m,
  input  logic                          stall_w,
  input  riscv_isa_pkg::word_t          exec_result_x,
  input  riscv_isa_pkg::word_t          dmem_resp_data,
  input  dpath_ctrl_pkg::mem_resp_sel_e mem_resp_sel_m,
  input  dpath_ctrl_pkg::wb_sel_e       wb_sel_m,
  output riscv_isa_pkg::word_t          wb_data_w
);

  riscv_isa_pkg::word_t exec_result_m;
  riscv_isa_pkg::word_t load_data_m;
  riscv_isa_pkg::word_t wb_data_m;

  // ------------------------------
  // M <- X
  // ------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      exec_result_m <= '0;
    end else if (!stall_m) begin
      exec_result_m <= exec_result_x;
    end
  end

  // Subword extraction from the low lanes
  always_comb begin
    case (mem_resp_sel_m)
      dpath_ctrl_pkg::resp_b:  load_data_m = {{24{dmem_resp_data[7]}}, dmem_resp_data[7:0]};
      dpath_ctrl_pkg::resp_bu: load_data_m = {24'b0, dmem_resp_data[7:0]};
      dpath_ctrl_pkg::resp_h:  load_data_m = {{16{dmem_resp_data[15]}}, dmem_resp_data[15:0]};
      dpath_ctrl_pkg::resp_hu: load_data_m = {16'b0, dmem_resp_data[15:0]};
      default:                 load_data_m = dmem_resp_data;  // lw
    endcase
  end

  assign wb_data_m = (wb_sel_m == dpath_ctrl_pkg::wb_mem) ? load_data_m : exec_result_m;

  // ------------------------------
  // W <- M
  // ------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_data_w <= '0;
    end else if (!stall_w) begin
      wb_data_w <= wb_data_m;  // Feeds the regfile write port
    end
  end

endmodule

/* riscv_dpath.sv */
// Five-stage RISC-V datapath top
// Connects fetch, decode, execute and memory/writeback stages

module riscv_dpath (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          stall_f,
  input  logic                          stall_d,
  input  logic                          stall_x,
  input  logic                          stall_m,
  input  logic                          stall_w,
  input  riscv_isa_pkg::inst_t          inst_d,
  input  dpath_ctrl_pkg::op0_sel_e      op0_sel_d,
  input  dpath_ctrl_pkg::op1_sel_e      op1_sel_d,
  input  dpath_ctrl_pkg::alu_fn_e       alu_fn_x,
  input  dpath_ctrl_pkg::brj_sel_e      brj_sel_x,
  input  dpath_ctrl_pkg::mem_resp_sel_e mem_resp_sel_m,
  input  dpath_ctrl_pkg::wb_sel_e       wb_sel_m,
  input  logic                          brj_taken_x,
  input  riscv_isa_pkg::word_t          dmem_resp_data,
  input  logic                          rf_wen_w,
  input  riscv_isa_pkg::reg_addr_t      rf_waddr_w,
  output riscv_isa_pkg::word_t          imem_addr,
  output riscv_isa_pkg::word_t          dmem_req_addr,
  output riscv_isa_pkg::word_t          dmem_req_data,
  output logic                          branch_cond_eq_x,
  output logic                          branch_cond_ne_x,
  output logic                          branch_cond_lt_x,
  output logic                          branch_cond_ltu_x,
  output logic                          branch_cond_ge_x,
  output logic                          branch_cond_geu_x,
  output riscv_isa_pkg::word_t          wb_data_w
);

  // ------------------------------
  // Inter-stage wires
  // ------------------------------

  riscv_isa_pkg::word_t pc_f;
  riscv_isa_pkg::word_t redirect_target_x;
  riscv_isa_pkg::word_t pc_d;
  riscv_isa_pkg::word_t op0_d;
  riscv_isa_pkg::word_t op1_d;
  riscv_isa_pkg::word_t rs1_val_d;
  riscv_isa_pkg::word_t rs2_val_d;
  riscv_isa_pkg::word_t imm_i_d;
  riscv_isa_pkg::word_t imm_sb_d;
  riscv_isa_pkg::word_t imm_uj_d;
  riscv_isa_pkg::word_t exec_result_x;

  fetch_unit u_fetch (
    .clk               (clk),
    .reset             (reset),
    .stall_f           (stall_f),
    .brj_taken_x       (brj_taken_x),
    .redirect_target_x (redirect_target_x),
    .pc_f              (pc_f),
    .imem_addr         (imem_addr)
  );

  decode_stage u_decode (
    .clk        (clk),
    .reset      (reset),
    .stall_d    (stall_d),
    .pc_f       (pc_f),
    .inst_d     (inst_d),
    .op0_sel_d  (op0_sel_d),
    .op1_sel_d  (op1_sel_d),
    .rf_wen_w   (rf_wen_w),
    .rf_waddr_w (rf_waddr_w),
    .wb_data_w  (wb_data_w),   // Writeback loops back from W
    .pc_d       (pc_d),
    .op0_d      (op0_d),
    .op1_d      (op1_d),
    .rs1_val_d  (rs1_val_d),
    .rs2_val_d  (rs2_val_d),
    .imm_i_d    (imm_i_d),
    .imm_sb_d   (imm_sb_d),
    .imm_uj_d   (imm_uj_d)
  );

  execute_stage u_execute (
    .clk               (clk),
    .reset             (reset),
    .stall_x           (stall_x),
    .pc_d              (pc_d),
    .op0_d             (op0_d),
    .op1_d             (op1_d),
    .rs1_val_d         (rs1_val_d),
    .rs2_val_d         (rs2_val_d),
    .imm_i_d           (imm_i_d),
    .imm_sb_d          (imm_sb_d),
    .imm_uj_d          (imm_uj_d),
    .alu_fn_x          (alu_fn_x),
    .brj_sel_x         (brj_sel_x),
    .brj_taken_x       (brj_taken_x),
    .exec_result_x     (exec_result_x),
    .store_data_x      (),              // Store data leaves on dmem_req_data
    .redirect_target_x (redirect_target_x),
    .dmem_req_addr     (dmem_req_addr),
    .dmem_req_data     (dmem_req_data),
    .branch_cond_eq_x  (branch_cond_eq_x),
    .branch_cond_ne_x  (branch_cond_ne_x),
    .branch_cond_lt_x  (branch_cond_lt_x),
    .branch_cond_ltu_x (branch_cond_ltu_x),
    .branch_cond_ge_x  (branch_cond_ge_x),
    .branch_cond_geu_x (branch_cond_geu_x)
  );

  mem_wb_stage u_mem_wb (
    .clk            (clk),
    .reset          (reset),
    .stall_m        (stall_m),
    .stall_w        (stall_w),
    .exec_result_x  (exec_result_x),
    .dmem_resp_data (dmem_resp_data),
    .mem_resp_sel_m (mem_resp_sel_m),
    .wb_sel_m       (wb_sel_m),
    .wb_data_w      (wb_data_w)
  );

endmodule

/* tb_clock_gen.sv */
// Testbench clock and reset
// 10-unit clock, reset held high for the first 10 cycles

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (10) @(negedge clk);
    reset = 1'b0;  // Released on a falling edge
  end

endmodule

/* riscv_dpath_tb.sv */
// Datapath testbench
// Table of instructions pushed through all stages, checked against a reference model

`include "dpath_params.svh"

module riscv_dpath_tb;

  localparam int NUM_ROWS  = 26;
  localparam int NUM_STEPS = NUM_ROWS + 3;  // Drain through X, M and W

  logic clk, reset;
  logic stall_f, stall_d, stall_x, stall_m, stall_w, brj_taken_x, rf_wen_w;
  riscv_isa_pkg::inst_t          inst_d;
  riscv_isa_pkg::word_t          dmem_resp_data, imem_addr, dmem_req_addr, dmem_req_data;
  riscv_isa_pkg::word_t          wb_data_w;
  riscv_isa_pkg::reg_addr_t      rf_waddr_w;
  dpath_ctrl_pkg::op0_sel_e      op0_sel_d;
  dpath_ctrl_pkg::op1_sel_e      op1_sel_d;
  dpath_ctrl_pkg::alu_fn_e       alu_fn_x;
  dpath_ctrl_pkg::brj_sel_e      brj_sel_x;
  dpath_ctrl_pkg::mem_resp_sel_e mem_resp_sel_m;
  dpath_ctrl_pkg::wb_sel_e       wb_sel_m;
  logic eq_x, ne_x, lt_x, ltu_x, ge_x, geu_x;

  // ------------------------------
  // Stimulus and expected table
  // ------------------------------
  riscv_isa_pkg::inst_t          t_inst [NUM_ROWS];
  dpath_ctrl_pkg::op0_sel_e      t_op0 [NUM_ROWS];
  dpath_ctrl_pkg::op1_sel_e      t_op1 [NUM_ROWS];
  dpath_ctrl_pkg::alu_fn_e       t_fn [NUM_ROWS];
  dpath_ctrl_pkg::brj_sel_e      t_bsel [NUM_ROWS];
  dpath_ctrl_pkg::mem_resp_sel_e t_resp [NUM_ROWS];
  dpath_ctrl_pkg::wb_sel_e       t_wbs [NUM_ROWS];
  logic                          t_taken [NUM_ROWS];
  logic                          t_wen [NUM_ROWS];
  riscv_isa_pkg::reg_addr_t      t_rd [NUM_ROWS];
  riscv_isa_pkg::word_t          t_rdata [NUM_ROWS];
  int                            t_stall [NUM_ROWS];   // Frozen cycles before the row
  riscv_isa_pkg::word_t e_op0 [NUM_ROWS], e_op1 [NUM_ROWS], e_rs2 [NUM_ROWS];
  riscv_isa_pkg::word_t e_wb [NUM_ROWS], e_target [NUM_ROWS];
  riscv_isa_pkg::word_t e_pc [NUM_STEPS+1];            // imem_addr per step
  riscv_isa_pkg::word_t rf_model [32];
  logic [31:0] lfsr_state = 32'haf99;
  int nrows = 0;

  tb_clock_gen clock_gen (.clk(clk), .reset(reset));

  riscv_dpath dut (
    .clk(clk), .reset(reset), .stall_f(stall_f), .stall_d(stall_d), .stall_x(stall_x),
    .stall_m(stall_m), .stall_w(stall_w), .inst_d(inst_d), .op0_sel_d(op0_sel_d),
    .op1_sel_d(op1_sel_d), .alu_fn_x(alu_fn_x), .brj_sel_x(brj_sel_x),
    .mem_resp_sel_m(mem_resp_sel_m), .wb_sel_m(wb_sel_m), .brj_taken_x(brj_taken_x),
    .dmem_resp_data(dmem_resp_data), .rf_wen_w(rf_wen_w), .rf_waddr_w(rf_waddr_w),
    .imem_addr(imem_addr), .dmem_req_addr(dmem_req_addr), .dmem_req_data(dmem_req_data),
    .branch_cond_eq_x(eq_x), .branch_cond_ne_x(ne_x), .branch_cond_lt_x(lt_x),
    .branch_cond_ltu_x(ltu_x), .branch_cond_ge_x(ge_x), .branch_cond_geu_x(geu_x),
    .wb_data_w(wb_data_w)
  );

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // Reference ALU from the ISA rules
  function automatic riscv_isa_pkg::word_t alu_model(input dpath_ctrl_pkg::alu_fn_e fn,
                                                     input riscv_isa_pkg::word_t a, b);
    case (fn)
      dpath_ctrl_pkg::alu_sub: return a - b;
      dpath_ctrl_pkg::alu_sll: return a << b[4:0];
      dpath_ctrl_pkg::alu_or:  return a | b;
      dpath_ctrl_pkg::alu_lt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      dpath_ctrl_pkg::alu_ltu: return (a < b) ? 32'd1 : 32'd0;
      dpath_ctrl_pkg::alu_and: return a & b;
      dpath_ctrl_pkg::alu_xor: return a ^ b;
      dpath_ctrl_pkg::alu_nor: return ~(a | b);
      dpath_ctrl_pkg::alu_srl: return a >> b[4:0];
      dpath_ctrl_pkg::alu_sra: return $unsigned($signed(a) >>> b[4:0]);
      default:                 return a + b;
    endcase
  endfunction

  // Argument order is op0, op1, fn, rs1, rs2, rd, wen, wb_sel, resp_sel, brj_sel, taken, stall
  task automatic add_row(input int op0, op1, fn, rs1, rs2, rd, wen, wbs, rsp, bs, tk, st);
    t_inst[nrows]  = {7'(rand_bits(7)), 5'(rs2), 5'(rs1), 3'(rand_bits(3)), 5'(rd),
                      7'(rand_bits(7))};
    t_op0[nrows]   = dpath_ctrl_pkg::op0_sel_e'(op0);
    t_op1[nrows]   = dpath_ctrl_pkg::op1_sel_e'(op1);
    t_fn[nrows]    = dpath_ctrl_pkg::alu_fn_e'(fn);
    t_rd[nrows]    = 5'(rd);
    t_wen[nrows]   = 1'(wen);
    t_wbs[nrows]   = dpath_ctrl_pkg::wb_sel_e'(wbs);
    t_resp[nrows]  = dpath_ctrl_pkg::mem_resp_sel_e'(rsp);
    t_bsel[nrows]  = dpath_ctrl_pkg::brj_sel_e'(bs);
    t_taken[nrows] = 1'(tk);
    t_stall[nrows] = st;
    t_rdata[nrows] = rand_bits(32);
    nrows++;
  endtask

  // Walks the rows in step order, mirroring register file and PC
  task automatic compute_expected();
    riscv_isa_pkg::inst_t i;
    riscv_isa_pkg::word_t pcd, rs1v, ld, imm_i, imm_s, imm_sb, imm_uj;
    e_pc[0] = `DPATH_RESET_VECTOR;
    for (int s = 0; s < NUM_STEPS; s++) begin
      if (s >= 4 && s - 4 < NUM_ROWS && t_wen[s-4] && t_rd[s-4] != 0)
        rf_model[t_rd[s-4]] = e_wb[s-4];  // Written at end of its W cycle
      if (s < NUM_ROWS) begin
        i      = t_inst[s];
        pcd    = (s == 0) ? 32'd0 : e_pc[s-1];
        rs1v   = (i[19:15] == 0) ? 32'd0 : rf_model[i[19:15]];
        e_rs2[s] = (i[24:20] == 0) ? 32'd0 : rf_model[i[24:20]];
        imm_i  = {{20{i[31]}}, i[31:20]};
        imm_s  = {{20{i[31]}}, i[31:25], i[11:7]};
        imm_sb = {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
        imm_uj = {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
        case (t_op0[s])
          dpath_ctrl_pkg::op0_rs1: e_op0[s] = rs1v;
          dpath_ctrl_pkg::op0_pc:  e_op0[s] = pcd;
          dpath_ctrl_pkg::op0_pc4: e_op0[s] = pcd + 4;
          default:                 e_op0[s] = '0;
        endcase
        case (t_op1[s])
          dpath_ctrl_pkg::op1_rs2:    e_op1[s] = e_rs2[s];
          dpath_ctrl_pkg::op1_shamt:  e_op1[s] = {27'b0, i[24:20]};
          dpath_ctrl_pkg::op1_imm_u:  e_op1[s] = {i[31:12], 12'b0};
          dpath_ctrl_pkg::op1_imm_sb: e_op1[s] = imm_sb;
          dpath_ctrl_pkg::op1_imm_i:  e_op1[s] = imm_i;
          dpath_ctrl_pkg::op1_imm_s:  e_op1[s] = imm_s;
          default:                    e_op1[s] = '0;
        endcase
        case (t_resp[s])
          dpath_ctrl_pkg::resp_b:  ld = {{24{t_rdata[s][7]}}, t_rdata[s][7:0]};
          dpath_ctrl_pkg::resp_bu: ld = {24'b0, t_rdata[s][7:0]};
          dpath_ctrl_pkg::resp_h:  ld = {{16{t_rdata[s][15]}}, t_rdata[s][15:0]};
          dpath_ctrl_pkg::resp_hu: ld = {16'b0, t_rdata[s][15:0]};
          default:                 ld = t_rdata[s];
        endcase
        e_wb[s] = (t_wbs[s] == dpath_ctrl_pkg::wb_mem) ? ld
                                                       : alu_model(t_fn[s], e_op0[s], e_op1[s]);
        case (t_bsel[s])
          dpath_ctrl_pkg::brj_branch: e_target[s] = pcd + imm_sb;
          dpath_ctrl_pkg::brj_jump:   e_target[s] = pcd + imm_uj;
          dpath_ctrl_pkg::brj_jreg:   e_target[s] = rs1v + imm_i;
          default:                    e_target[s] = pcd + 4;
        endcase
      end
      // Redirect from the row now in X
      if (s >= 1 && s - 1 < NUM_ROWS && t_taken[s-1]) e_pc[s+1] = e_target[s-1];
      else e_pc[s+1] = e_pc[s] + 4;
    end
  endtask

  task automatic check_word(input string what, input riscv_isa_pkg::word_t got, exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_flag(input string what, input logic got, exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: flag %s is %b, expected %b", $time, what, got, exp);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  // Each stage takes its controls from the row it holds
  task automatic drive_step(input int s, input logic frz);
    {stall_f, stall_d, stall_x, stall_m, stall_w} = {5{frz}};
    inst_d    = (s < NUM_ROWS) ? t_inst[s] : '0;
    op0_sel_d = (s < NUM_ROWS) ? t_op0[s] : dpath_ctrl_pkg::op0_zero;
    op1_sel_d = (s < NUM_ROWS) ? t_op1[s] : dpath_ctrl_pkg::op1_zero;
    alu_fn_x    = (s >= 1 && s - 1 < NUM_ROWS) ? t_fn[s-1] : dpath_ctrl_pkg::alu_add;
    brj_sel_x   = (s >= 1 && s - 1 < NUM_ROWS) ? t_bsel[s-1] : dpath_ctrl_pkg::brj_pc4;
    brj_taken_x = (s >= 1 && s - 1 < NUM_ROWS) ? t_taken[s-1] : 1'b0;
    mem_resp_sel_m = (s >= 2 && s - 2 < NUM_ROWS) ? t_resp[s-2] : dpath_ctrl_pkg::resp_w;
    wb_sel_m       = (s >= 2 && s - 2 < NUM_ROWS) ? t_wbs[s-2] : dpath_ctrl_pkg::wb_exec;
    dmem_resp_data = (s >= 2 && s - 2 < NUM_ROWS) ? t_rdata[s-2] : '0;
    rf_wen_w   = (s >= 3 && s - 3 < NUM_ROWS) ? t_wen[s-3] : 1'b0;
    rf_waddr_w = (s >= 3 && s - 3 < NUM_ROWS) ? t_rd[s-3] : '0;
  endtask

  task automatic check_step(input int s);
    riscv_isa_pkg::word_t a, b;
    check_word("imem_addr", imem_addr, e_pc[s]);
    if (s == 0) begin  // Zeroed X operands after reset
      check_flag("eq", eq_x, 1'b1);
      check_flag("ne", ne_x, 1'b0);
      check_flag("lt", lt_x, 1'b0);
      check_flag("ltu", ltu_x, 1'b0);
      check_flag("ge", ge_x, 1'b1);
      check_flag("geu", geu_x, 1'b1);
    end else if (s - 1 < NUM_ROWS) begin
      a = e_op0[s-1];
      b = e_op1[s-1];
      check_flag("eq", eq_x, a == b);
      check_flag("ne", ne_x, a != b);
      check_flag("lt", lt_x, $signed(a) < $signed(b));
      check_flag("ltu", ltu_x, a < b);
      check_flag("ge", ge_x, $signed(a) >= $signed(b));
      check_flag("geu", geu_x, a >= b);
      check_word("dmem_req_addr", dmem_req_addr, alu_model(t_fn[s-1], a, b));
      check_word("dmem_req_data", dmem_req_data, e_rs2[s-1]);
    end
    if (s < 3) check_word("wb_data_w", wb_data_w, '0);
    else if (s - 3 < NUM_ROWS) check_word("wb_data_w", wb_data_w, e_wb[s-3]);
  endtask

  // Watchdog
  initial begin
    #((NUM_ROWS * 10 + 10) * 10);
    $display("Timeout: the run did not finish in the expected number of cycles");
    $display("Test FAILED");
    $fatal(1);
  end

  initial begin
    bit first;
    drive_step(NUM_STEPS, 1'b0);  // All inputs idle during reset
    //       op0 op1 fn rs1 rs2 rd wen wbs rsp bs tk st
    add_row(3, 4, 0, 0, 0, 1, 1, 0, 0, 0, 0, 0);     // x1 = imm_i
    add_row(3, 2, 0, 0, 0, 2, 1, 0, 0, 0, 0, 0);     // x2 = imm_u
    add_row(3, 5, 0, 0, 0, 3, 1, 0, 0, 0, 0, 0);     // x3 = imm_s
    add_row(1, 3, 0, 0, 0, 4, 1, 0, 0, 0, 0, 0);     // x4 = pc + imm_sb
    add_row(2, 6, 0, 0, 0, 5, 1, 0, 0, 0, 0, 0);     // x5 = pc + 4
    add_row(0, 0, 1, 1, 2, 6, 1, 0, 0, 0, 0, 0);     // sub
    add_row(0, 1, 2, 1, 9, 7, 1, 0, 0, 0, 0, 0);     // sll by shamt
    add_row(0, 0, 3, 3, 4, 8, 1, 0, 0, 0, 0, 0);     // or
    add_row(0, 0, 4, 1, 2, 9, 1, 0, 0, 0, 0, 0);     // lt
    add_row(0, 0, 5, 2, 1, 10, 1, 0, 0, 0, 0, 0);    // ltu
    add_row(0, 0, 6, 4, 5, 11, 1, 0, 0, 0, 0, 0);    // and
    add_row(0, 0, 7, 6, 7, 12, 1, 0, 0, 0, 0, 0);    // xor
    add_row(0, 0, 8, 8, 1, 13, 1, 0, 0, 0, 0, 0);    // nor
    add_row(0, 1, 9, 2, 13, 14, 1, 0, 0, 0, 0, 0);   // srl
    add_row(0, 1, 10, 2, 31, 15, 1, 0, 0, 0, 0, 0);  // sra
    add_row(0, 0, 0, 3, 3, 0, 1, 0, 0, 0, 0, 0);     // Write to x0 is dropped
    add_row(0, 0, 1, 1, 2, 0, 0, 0, 0, 1, 1, 0);     // Branch taken
    add_row(0, 0, 1, 6, 7, 0, 0, 0, 0, 2, 1, 0);     // Jump taken
    add_row(0, 4, 0, 3, 0, 0, 0, 0, 0, 3, 1, 0);     // Jump-register taken
    add_row(0, 0, 0, 0, 1, 16, 1, 0, 0, 0, 0, 0);    // x0 + x1
    add_row(0, 5, 0, 1, 2, 17, 1, 1, 0, 0, 0, 0);    // lw
    add_row(0, 5, 0, 3, 4, 18, 1, 1, 1, 0, 0, 0);    // lb
    add_row(0, 5, 0, 5, 6, 19, 1, 1, 2, 0, 0, 2);    // lbu after 2 frozen cycles
    add_row(0, 5, 0, 7, 8, 20, 1, 1, 3, 0, 0, 0);    // lh
    add_row(0, 5, 0, 9, 10, 21, 1, 1, 4, 0, 0, 0);   // lhu
    add_row(0, 0, 0, 16, 17, 22, 1, 0, 0, 0, 0, 0);  // Reads back loaded registers
    compute_expected();
    first = 1'b1;
    @(negedge reset);
    for (int s = 0; s < NUM_STEPS; s++) begin
      for (int k = 0; k <= ((s < NUM_ROWS) ? t_stall[s] : 0); k++) begin
        if (!first) @(negedge clk);
        first = 1'b0;
        drive_step(s, (s < NUM_ROWS) && (k < t_stall[s]));
        #2;  // Settle inside the low phase
        check_step(s);
      end
    end
    $display("Test OK");
    $finish;
  end

endmodule

/* sources.f */
+incdir+.
riscv_isa_pkg.sv
dpath_ctrl_pkg.sv
fetch_unit.sv
regfile.sv
decode_stage.sv
alu.sv
execute_stage.sv
mem_wb_stage.sv
riscv_dpath.sv
tb_clock_gen.sv
riscv_dpath_tb.sv
